// File: hdl/cnn_defs.svh
`ifndef CNN_DEFS_SVH
`define CNN_DEFS_SVH

// ======================================================================
// frame geometry
// ======================================================================
`define CNN_IMG_DIM        6      // image side
`define CNN_KER_DIM        3      // kernel side
`define CNN_FMAP_DIM       4      // img - ker + 1
`define CNN_POOL_OUTS      4      // one per 2x2 quadrant
`define CNN_FC_OUTS        4      // dense rows

// ======================================================================
// stream layout
// ======================================================================
`define CNN_FRAME_BEATS    36     // one pixel per channel per beat
`define CNN_KER_BEATS      9      // kernel entries on beats 0..8
`define CNN_WEIGHT_BEATS   16     // weights on beats 0..15

// quantizer
`define CNN_QUANT_SHIFT    9
`define CNN_QUANT_MAX_IN   65023
`define CNN_QUANT_MIN_IN   (-65024)

`endif

// File: hdl/cnn_pkg.sv
package cnn_pkg;

    // ==================================================================
    // data widths
    // ==================================================================
    typedef logic signed [7:0]  pixel_t;    // pixel, kernel entry, weight
    typedef logic signed [20:0] acc_t;      // feature map accumulator
    typedef logic signed [7:0]  qval_t;     // quantized pooled value
    typedef logic signed [19:0] result_t;   // dense output

    // ==================================================================
    // modes and state machines
    // ==================================================================
    typedef enum logic {
        ACT_RELU = 1'b0,
        ACT_ABS  = 1'b1
    } act_mode_t;

    typedef enum logic {
        LOAD_IDLE,
        LOAD_RX
    } load_state_t;

    typedef enum logic {
        CONV_IDLE,
        CONV_RUN
    } conv_state_t;

endpackage

// File: hdl/cnn_input_loader.sv
`timescale 1ns/1ps
`include "cnn_defs.svh"

module cnn_input_loader (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_valid,
    input  logic                i_mode,
    input  cnn_pkg::pixel_t     i_data_ch1,
    input  cnn_pkg::pixel_t     i_data_ch2,
    input  cnn_pkg::pixel_t     i_kernel_ch1,
    input  cnn_pkg::pixel_t     i_kernel_ch2,
    input  cnn_pkg::pixel_t     i_weight,
    input  logic                i_busy,
    output logic                o_load_done,
    output cnn_pkg::act_mode_t  o_mode,
    output cnn_pkg::pixel_t     o_image_ch1  [`CNN_IMG_DIM][`CNN_IMG_DIM],
    output cnn_pkg::pixel_t     o_image_ch2  [`CNN_IMG_DIM][`CNN_IMG_DIM],
    output cnn_pkg::pixel_t     o_kernel_ch1 [`CNN_KER_DIM][`CNN_KER_DIM],
    output cnn_pkg::pixel_t     o_kernel_ch2 [`CNN_KER_DIM][`CNN_KER_DIM],
    output cnn_pkg::pixel_t     o_weights    [`CNN_FC_OUTS][`CNN_POOL_OUTS]
);

    cnn_pkg::load_state_t state;
    logic [5:0]           beat_cnt;     // index of the beat being sampled
    logic                 beat_ok;

    // a new frame may only open while the engine is idle
    assign beat_ok = i_valid && (state == cnn_pkg::LOAD_RX || !i_busy);

    // ==================================================================
    // frame sequencing
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= cnn_pkg::LOAD_IDLE;
            beat_cnt    <= 6'd0;
            o_load_done <= 1'b0;
        end
        else
        begin
            o_load_done <= 1'b0;
            case (state)
                cnn_pkg::LOAD_IDLE:
                begin
                    if (beat_ok)
                    begin
                        state    <= cnn_pkg::LOAD_RX;
                        beat_cnt <= 6'd1;
                    end
                end
                default:
                begin
                    if (!i_valid)
                    begin
                        state    <= cnn_pkg::LOAD_IDLE;   // gap, drop partial frame
                        beat_cnt <= 6'd0;
                    end
                    else if (beat_cnt == `CNN_FRAME_BEATS - 1)
                    begin
                        state       <= cnn_pkg::LOAD_IDLE;
                        beat_cnt    <= 6'd0;
                        o_load_done <= 1'b1;
                    end
                    else
                        beat_cnt <= beat_cnt + 6'd1;
                end
            endcase
        end
    end

    // ==================================================================
    // beat steering into the stores
    // ==================================================================
    always_ff @(posedge clk)
    begin
        if (beat_ok)
        begin
            if (beat_cnt == 6'd0)
                o_mode <= cnn_pkg::act_mode_t'(i_mode);
            for (int r = 0; r < `CNN_IMG_DIM; r++)
                for (int c = 0; c < `CNN_IMG_DIM; c++)
                    if (beat_cnt == r * `CNN_IMG_DIM + c)
                    begin
                        o_image_ch1[r][c] <= i_data_ch1;
                        o_image_ch2[r][c] <= i_data_ch2;
                    end
            if (beat_cnt < `CNN_KER_BEATS)
            begin
                for (int r = 0; r < `CNN_KER_DIM; r++)
                    for (int c = 0; c < `CNN_KER_DIM; c++)
                        if (beat_cnt == r * `CNN_KER_DIM + c)
                        begin
                            o_kernel_ch1[r][c] <= i_kernel_ch1;
                            o_kernel_ch2[r][c] <= i_kernel_ch2;
                        end
            end
            if (beat_cnt < `CNN_WEIGHT_BEATS)
            begin
                for (int r = 0; r < `CNN_FC_OUTS; r++)
                    for (int c = 0; c < `CNN_POOL_OUTS; c++)
                        if (beat_cnt == r * `CNN_POOL_OUTS + c)
                            o_weights[r][c] <= i_weight;    // row r feeds output r
            end
        end
    end

endmodule

// File: hdl/cnn_conv_engine.sv
`timescale 1ns/1ps
`include "cnn_defs.svh"

module cnn_conv_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_start,
    input  cnn_pkg::act_mode_t  i_mode,
    input  cnn_pkg::pixel_t     i_image_ch1  [`CNN_IMG_DIM][`CNN_IMG_DIM],
    input  cnn_pkg::pixel_t     i_image_ch2  [`CNN_IMG_DIM][`CNN_IMG_DIM],
    input  cnn_pkg::pixel_t     i_kernel_ch1 [`CNN_KER_DIM][`CNN_KER_DIM],
    input  cnn_pkg::pixel_t     i_kernel_ch2 [`CNN_KER_DIM][`CNN_KER_DIM],
    output cnn_pkg::acc_t       o_fmap [`CNN_FMAP_DIM][`CNN_FMAP_DIM],
    output logic                o_fmap_valid,
    output logic                o_busy
);

    cnn_pkg::conv_state_t state;
    logic [3:0]           pos;          // row-major map position
    logic [1:0]           row;
    logic [1:0]           col;
    cnn_pkg::acc_t        conv_sum;
    cnn_pkg::acc_t        act_val;

    assign row = pos[3:2];
    assign col = pos[1:0];

    // start pulse through the last map write
    assign o_busy = i_start || (state == cnn_pkg::CONV_RUN) || o_fmap_valid;

    // ==================================================================
    // window products, both channels
    // ==================================================================
    always_comb
    begin
        conv_sum = '0;
        for (int m = 0; m < `CNN_KER_DIM; m++)
            for (int n = 0; n < `CNN_KER_DIM; n++)
                conv_sum = conv_sum
                         + i_image_ch1[row + m][col + n] * i_kernel_ch1[m][n]
                         + i_image_ch2[row + m][col + n] * i_kernel_ch2[m][n];
    end

    // activation
    always_comb
    begin
        if (conv_sum < 0)
            act_val = (i_mode == cnn_pkg::ACT_ABS) ? -conv_sum : '0;
        else
            act_val = conv_sum;
    end

    // ==================================================================
    // position walk
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state        <= cnn_pkg::CONV_IDLE;
            pos          <= 4'd0;
            o_fmap_valid <= 1'b0;
        end
        else
        begin
            o_fmap_valid <= 1'b0;
            case (state)
                cnn_pkg::CONV_IDLE:
                begin
                    pos <= 4'd0;
                    if (i_start)
                        state <= cnn_pkg::CONV_RUN;
                end
                default:
                begin
                    if (pos == `CNN_FMAP_DIM * `CNN_FMAP_DIM - 1)
                    begin
                        state        <= cnn_pkg::CONV_IDLE;
                        pos          <= 4'd0;
                        o_fmap_valid <= 1'b1;   // whole map written
                    end
                    else
                        pos <= pos + 4'd1;
                end
            endcase
        end
    end

    // map register, one entry per cycle
    always_ff @(posedge clk)
    begin
        if (state == cnn_pkg::CONV_RUN)
            o_fmap[row][col] <= act_val;
    end

endmodule

// File: hdl/cnn_pool_quant.sv
`timescale 1ns/1ps
`include "cnn_defs.svh"

module cnn_pool_quant (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           i_fmap_valid,
    input  cnn_pkg::acc_t  i_fmap [`CNN_FMAP_DIM][`CNN_FMAP_DIM],
    output cnn_pkg::qval_t o_qvec [`CNN_POOL_OUTS],
    output logic           o_qvec_valid
);

    cnn_pkg::acc_t  pool_max  [`CNN_POOL_OUTS];
    cnn_pkg::qval_t qvec_next [`CNN_POOL_OUTS];

    function automatic cnn_pkg::acc_t max2(input cnn_pkg::acc_t a, input cnn_pkg::acc_t b);
        return (a > b) ? a : b;
    endfunction

    // saturate, else arithmetic shift
    function automatic cnn_pkg::qval_t quantize(input cnn_pkg::acc_t x);
        cnn_pkg::acc_t shifted;
        shifted = x >>> `CNN_QUANT_SHIFT;
        if (x > `CNN_QUANT_MAX_IN)
            return 8'sd127;
        else if (x < `CNN_QUANT_MIN_IN)
            return -8'sd128;
        else
            return shifted[7:0];
    endfunction

    // ==================================================================
    // 2x2 pooling and quantization
    // ==================================================================
    always_comb
    begin
        for (int q = 0; q < `CNN_POOL_OUTS; q++)
        begin
            // quadrant order tl, tr, bl, br
            pool_max[q] = max2(max2(i_fmap[(q / 2) * 2][(q % 2) * 2],
                                    i_fmap[(q / 2) * 2][(q % 2) * 2 + 1]),
                               max2(i_fmap[(q / 2) * 2 + 1][(q % 2) * 2],
                                    i_fmap[(q / 2) * 2 + 1][(q % 2) * 2 + 1]));
            qvec_next[q] = quantize(pool_max[q]);
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_qvec_valid <= 1'b0;
        else
            o_qvec_valid <= i_fmap_valid;
    end

    always_ff @(posedge clk)
    begin
        if (i_fmap_valid)
            o_qvec <= qvec_next;    // held until the next frame
    end

endmodule

// File: hdl/cnn_dense_output.sv
`timescale 1ns/1ps
`include "cnn_defs.svh"

module cnn_dense_output (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_qvec_valid,
    input  cnn_pkg::qval_t   i_qvec    [`CNN_POOL_OUTS],
    input  cnn_pkg::pixel_t  i_weights [`CNN_FC_OUTS][`CNN_POOL_OUTS],
    output logic             o_valid,
    output cnn_pkg::result_t o_data,
    output logic             o_busy_tail
);

    logic [1:0]       beat_cnt;     // wraps to 0 after the last row
    logic             active;
    cnn_pkg::result_t row_dot;

    // ==================================================================
    // dot product of the current weight row
    // ==================================================================
    always_comb
    begin
        row_dot = '0;
        for (int c = 0; c < `CNN_POOL_OUTS; c++)
            row_dot = row_dot + i_qvec[c] * i_weights[beat_cnt][c];
    end

    // beats still to come, plus the one on the bus
    assign o_busy_tail = active || o_valid;

    // ==================================================================
    // output serializer
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            beat_cnt <= 2'd0;
            active   <= 1'b0;
            o_valid  <= 1'b0;
            o_data   <= '0;
        end
        else if (i_qvec_valid || active)
        begin
            o_valid  <= 1'b1;
            o_data   <= row_dot;
            beat_cnt <= beat_cnt + 2'd1;
            active   <= (beat_cnt != 2'd3);
        end
        else
        begin
            o_valid <= 1'b0;
            o_data  <= '0;      // bus is zero between frames
        end
    end

endmodule

// File: hdl/cnn_top.sv
`timescale 1ns/1ps
`include "cnn_defs.svh"

module cnn_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_valid,
    input  logic             i_mode,
    input  cnn_pkg::pixel_t  i_data_ch1,
    input  cnn_pkg::pixel_t  i_data_ch2,
    input  cnn_pkg::pixel_t  i_kernel_ch1,
    input  cnn_pkg::pixel_t  i_kernel_ch2,
    input  cnn_pkg::pixel_t  i_weight,
    output logic             o_valid,
    output cnn_pkg::result_t o_data
);

    logic               load_done;
    cnn_pkg::act_mode_t mode;
    cnn_pkg::pixel_t    image_ch1  [`CNN_IMG_DIM][`CNN_IMG_DIM];
    cnn_pkg::pixel_t    image_ch2  [`CNN_IMG_DIM][`CNN_IMG_DIM];
    cnn_pkg::pixel_t    kernel_ch1 [`CNN_KER_DIM][`CNN_KER_DIM];
    cnn_pkg::pixel_t    kernel_ch2 [`CNN_KER_DIM][`CNN_KER_DIM];
    cnn_pkg::pixel_t    weights    [`CNN_FC_OUTS][`CNN_POOL_OUTS];
    cnn_pkg::acc_t      fmap       [`CNN_FMAP_DIM][`CNN_FMAP_DIM];
    logic               fmap_valid;
    cnn_pkg::qval_t     qvec       [`CNN_POOL_OUTS];
    logic               qvec_valid;
    logic               conv_busy;
    logic               busy_tail;
    logic               busy;

    // engine span, pooling cycle, then output beats
    assign busy = conv_busy | qvec_valid | busy_tail;

    cnn_input_loader u_input_loader (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_valid      (i_valid),
        .i_mode       (i_mode),
        .i_data_ch1   (i_data_ch1),
        .i_data_ch2   (i_data_ch2),
        .i_kernel_ch1 (i_kernel_ch1),
        .i_kernel_ch2 (i_kernel_ch2),
        .i_weight     (i_weight),
        .i_busy       (busy),
        .o_load_done  (load_done),
        .o_mode       (mode),
        .o_image_ch1  (image_ch1),
        .o_image_ch2  (image_ch2),
        .o_kernel_ch1 (kernel_ch1),
        .o_kernel_ch2 (kernel_ch2),
        .o_weights    (weights)
    );

    cnn_conv_engine u_conv_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_start      (load_done),
        .i_mode       (mode),
        .i_image_ch1  (image_ch1),
        .i_image_ch2  (image_ch2),
        .i_kernel_ch1 (kernel_ch1),
        .i_kernel_ch2 (kernel_ch2),
        .o_fmap       (fmap),
        .o_fmap_valid (fmap_valid),
        .o_busy       (conv_busy)
    );

    cnn_pool_quant u_pool_quant (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_fmap_valid (fmap_valid),
        .i_fmap       (fmap),
        .o_qvec       (qvec),
        .o_qvec_valid (qvec_valid)
    );

    cnn_dense_output u_dense_output (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_qvec_valid (qvec_valid),
        .i_qvec       (qvec),
        .i_weights    (weights),
        .o_valid      (o_valid),
        .o_data       (o_data),
        .o_busy_tail  (busy_tail)
    );

endmodule

// File: verification/cnn_tb.sv
`timescale 1ns/1ps
`include "cnn_defs.svh"

module cnn_tb;

    localparam int NUM_FRAMES  = 19;                // every frame sent including the cut one
    localparam int WATCHDOG_NS = NUM_FRAMES * 80 * 8 + 1000;
    localparam int OUT_LATENCY = 20;                // last input edge to first o_valid edge

    logic             clk = 1'b0;
    logic             rst_n;
    logic             i_valid;
    logic             i_mode;
    cnn_pkg::pixel_t  i_data_ch1;
    cnn_pkg::pixel_t  i_data_ch2;
    cnn_pkg::pixel_t  i_kernel_ch1;
    cnn_pkg::pixel_t  i_kernel_ch2;
    cnn_pkg::pixel_t  i_weight;
    logic             o_valid;
    cnn_pkg::result_t o_data;

    // current frame contents
    cnn_pkg::pixel_t  img1 [`CNN_IMG_DIM][`CNN_IMG_DIM];
    cnn_pkg::pixel_t  img2 [`CNN_IMG_DIM][`CNN_IMG_DIM];
    cnn_pkg::pixel_t  ker1 [`CNN_KER_DIM][`CNN_KER_DIM];
    cnn_pkg::pixel_t  ker2 [`CNN_KER_DIM][`CNN_KER_DIM];
    cnn_pkg::pixel_t  wgt  [`CNN_FC_OUTS][`CNN_POOL_OUTS];
    logic             frame_mode;

    cnn_pkg::result_t exp_q [$];
    int               edge_q [$];                   // edge that sampled each last beat
    int               cycle_cnt = 0;
    int               last_edge;
    int               out_beat = 0;
    int               frames_sent = 0;
    int               frames_done = 0;
    int               mismatch_errs = 0;
    int               timing_errs = 0;
    int               other_errs = 0;
    int               seed_val;

    always #4 clk = ~clk;

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    cnn_top u_cnn_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_valid      (i_valid),
        .i_mode       (i_mode),
        .i_data_ch1   (i_data_ch1),
        .i_data_ch2   (i_data_ch2),
        .i_kernel_ch1 (i_kernel_ch1),
        .i_kernel_ch2 (i_kernel_ch2),
        .i_weight     (i_weight),
        .o_valid      (o_valid),
        .o_data       (o_data)
    );

    // ==================================================================
    // reference model
    // ==================================================================
    function automatic cnn_pkg::result_t ref_output(input int r);
        int conv [`CNN_FMAP_DIM][`CNN_FMAP_DIM];
        int q [`CNN_POOL_OUTS];
        int acc;
        int pooled;
        for (int i = 0; i < `CNN_FMAP_DIM; i++)
            for (int j = 0; j < `CNN_FMAP_DIM; j++)
            begin
                acc = 0;
                for (int m = 0; m < `CNN_KER_DIM; m++)
                    for (int n = 0; n < `CNN_KER_DIM; n++)
                        acc = acc + int'(img1[i + m][j + n]) * int'(ker1[m][n])
                                  + int'(img2[i + m][j + n]) * int'(ker2[m][n]);
                if (acc < 0)
                    acc = frame_mode ? -acc : 0;    // abs in mode 1, relu in mode 0
                conv[i][j] = acc;
            end
        for (int p = 0; p < `CNN_POOL_OUTS; p++)
        begin
            pooled = conv[(p / 2) * 2][(p % 2) * 2];
            for (int a = 0; a < 2; a++)
                for (int b = 0; b < 2; b++)
                    if (conv[(p / 2) * 2 + a][(p % 2) * 2 + b] > pooled)
                        pooled = conv[(p / 2) * 2 + a][(p % 2) * 2 + b];
            if (pooled > `CNN_QUANT_MAX_IN)
                q[p] = 127;
            else if (pooled < `CNN_QUANT_MIN_IN)
                q[p] = -128;
            else
                q[p] = pooled >>> `CNN_QUANT_SHIFT;
        end
        acc = 0;
        for (int c = 0; c < `CNN_POOL_OUTS; c++)
            acc = acc + q[c] * int'(wgt[r][c]);
        return cnn_pkg::result_t'(acc);
    endfunction

    // kind 1 large positive, kind 2 large negative, else full range
    function automatic cnn_pkg::pixel_t rand_pixel(input int kind);
        int v;
        case (kind)
            1:       v = 96 + ($urandom % 32);
            2:       v = -128 + ($urandom % 32);
            default: v = ($urandom % 256) - 128;
        endcase
        return cnn_pkg::pixel_t'(v);
    endfunction

    // ==================================================================
    // checks
    // ==================================================================
    task automatic compare_result(input string name, input cnn_pkg::result_t got,
                                  input cnn_pkg::result_t exp);
        if (got !== exp)
        begin
            mismatch_errs++;
            $display("MISMATCH %s: got 0x%05h expected 0x%05h", name, got, exp);
        end
    endtask

    task automatic check_cycles(input string what, input int got, input int exp);
        if (got != exp)
        begin
            timing_errs++;
            $display("timing error: %s was %0d cycles, expected %0d", what, got, exp);
        end
    endtask

    // output monitor sampled mid-cycle
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (o_valid)
            begin
                if (out_beat == 0 && edge_q.size() != 0)
                    check_cycles("output latency", cycle_cnt + 1 - edge_q.pop_front(),
                                 OUT_LATENCY);
                if (exp_q.size() == 0)
                begin
                    other_errs++;
                    $display("o_valid went high with no complete frame pending");
                end
                else
                    compare_result($sformatf("o_data beat %0d", out_beat), o_data,
                                   exp_q.pop_front());
                out_beat++;
            end
            else
            begin
                compare_result("o_data while idle", o_data, '0);
                if (out_beat != 0)
                begin
                    check_cycles("o_valid length", out_beat, `CNN_FC_OUTS);
                    out_beat = 0;
                    frames_done++;
                end
            end
        end
    end

    // ==================================================================
    // stimulus
    // ==================================================================
    task automatic fill_frame(input int img_kind, input int ker_kind);
        for (int r = 0; r < `CNN_IMG_DIM; r++)
            for (int c = 0; c < `CNN_IMG_DIM; c++)
            begin
                img1[r][c] = rand_pixel(img_kind);
                img2[r][c] = rand_pixel(img_kind);
            end
        for (int r = 0; r < `CNN_KER_DIM; r++)
            for (int c = 0; c < `CNN_KER_DIM; c++)
            begin
                ker1[r][c] = rand_pixel(ker_kind);
                ker2[r][c] = rand_pixel(ker_kind);
            end
        for (int r = 0; r < `CNN_FC_OUTS; r++)
            for (int c = 0; c < `CNN_POOL_OUTS; c++)
                wgt[r][c] = rand_pixel(0);
    endtask

    task automatic send_beats(input logic mode, input int n_beats);
        for (int k = 0; k < n_beats; k++)
        begin
            @(posedge clk);
            i_valid      <= 1'b1;
            i_mode       <= mode;
            i_data_ch1   <= img1[k / `CNN_IMG_DIM][k % `CNN_IMG_DIM];
            i_data_ch2   <= img2[k / `CNN_IMG_DIM][k % `CNN_IMG_DIM];
            i_kernel_ch1 <= (k < `CNN_KER_BEATS) ? ker1[k / 3][k % 3] : rand_pixel(0);
            i_kernel_ch2 <= (k < `CNN_KER_BEATS) ? ker2[k / 3][k % 3] : rand_pixel(0);
            i_weight     <= (k < `CNN_WEIGHT_BEATS) ? wgt[k / 4][k % 4] : rand_pixel(0);
        end
        @(posedge clk);
        i_valid   <= 1'b0;
        last_edge = cycle_cnt + 1;  // this edge samples the final beat
    endtask

    // random beats while a frame is in flight
    task automatic send_busy_beats(input logic mode, input int n_beats);
        for (int k = 0; k < n_beats; k++)
        begin
            @(posedge clk);
            i_valid      <= 1'b1;
            i_mode       <= ~mode;
            i_data_ch1   <= rand_pixel(0);
            i_data_ch2   <= rand_pixel(0);
            i_kernel_ch1 <= rand_pixel(0);
            i_kernel_ch2 <= rand_pixel(0);
            i_weight     <= rand_pixel(0);
        end
        @(posedge clk);
        i_valid <= 1'b0;
    endtask

    task automatic run_frame(input logic mode, input int img_kind, input int ker_kind,
                             input int gap, input int busy_beats);
        repeat (gap) @(posedge clk);
        fill_frame(img_kind, ker_kind);
        frame_mode = mode;
        send_beats(mode, `CNN_FRAME_BEATS);
        for (int r = 0; r < `CNN_FC_OUTS; r++)
            exp_q.push_back(ref_output(r));
        edge_q.push_back(last_edge);
        frames_sent++;
        if (busy_beats > 0)
            send_busy_beats(mode, busy_beats);  // all of them land in the busy span
        wait (frames_done == frames_sent);
    endtask

    initial
    begin
        seed_val     = $urandom(70699);
        rst_n        = 1'b0;
        i_valid      = 1'b0;
        i_mode       = 1'b0;
        i_data_ch1   = '0;
        i_data_ch2   = '0;
        i_kernel_ch1 = '0;
        i_kernel_ch2 = '0;
        i_weight     = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (20) @(posedge clk);     // monitor flags any output here

        for (int i = 0; i < 4; i++)
            run_frame(1'b0, 0, 0, 3, 0);
        for (int i = 0; i < 4; i++)
            run_frame(1'b1, 0, 0, 3, 0);

        // large magnitudes push pooled values past the clamp
        run_frame(1'b0, 1, 1, 3, 0);
        run_frame(1'b1, 1, 2, 3, 0);
        run_frame(1'b0, 2, 2, 3, 0);
        run_frame(1'b1, 0, 1, 3, 0);

        // cut after 20 beats
        fill_frame(0, 0);
        send_beats(1'b1, 20);
        repeat (40) @(posedge clk);
        run_frame(1'b0, 0, 0, 3, 0);

        for (int i = 0; i < 4; i++)
            run_frame(i[0], 0, 0, 0, 0);

        // beats that arrive while busy are ignored
        run_frame(1'b1, 0, 0, 3, 20);

        repeat (10) @(posedge clk);
        if (exp_q.size() != 0)
        begin
            other_errs++;
            $display("%0d expected results never appeared on the output", exp_q.size());
        end
        $display("errors: %0d mismatch, %0d timing, %0d other",
                 mismatch_errs, timing_errs, other_errs);
        if (mismatch_errs + timing_errs + other_errs == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("run stopped by watchdog after %0d ns", WATCHDOG_NS);
        $display("errors: %0d mismatch, %0d timing, %0d other",
                 mismatch_errs, timing_errs, other_errs);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: files.f
+incdir+hdl
hdl/cnn_pkg.sv
hdl/cnn_input_loader.sv
hdl/cnn_conv_engine.sv
hdl/cnn_pool_quant.sv
hdl/cnn_dense_output.sv
hdl/cnn_top.sv
verification/cnn_tb.sv
